//--- src/host_pkg.sv
/*
  host package
  address map, bus widths, opcode type and the fixed boot image
  shared by the loader, router, memory and host register block
*/
`default_nettype none

package host_pkg;

  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;

  // backing memory, word addressed by addr[9:2]
  localparam int MEM_WORDS = 256;
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);

  // bit 15 selects the host register block
  localparam logic [ADDR_W-1:0] HOST_BASE       = 16'h8000;
  localparam logic [ADDR_W-1:0] HOST_ENABLE_OFS = 16'h0000;
  localparam logic [ADDR_W-1:0] HOST_FINISH_OFS = 16'h0004;
  localparam logic [DATA_W-1:0] HOST_BAD_RDATA  = 32'hDEAD_BEEF;

  localparam int TRACE_W = 8;
  localparam int CODE_W  = 8;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // boot image, one write command per entry
  localparam int NBF_LEN   = 8;
  localparam int NBF_IDX_W = $clog2(NBF_LEN);

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } nbf_entry_t;

  localparam nbf_entry_t nbf_image [NBF_LEN] = '{
    '{16'h0000, 32'h1000_0000},
    '{16'h0004, 32'h1000_0101},
    '{16'h0008, 32'h1000_0202},
    '{16'h000C, 32'h1000_0303},
    '{16'h0010, 32'h1000_0404},
    '{16'h0014, 32'h1000_0505},
    '{16'h0018, 32'h1000_0606},
    // last entry turns on two of the trace enables
    '{HOST_BASE + HOST_ENABLE_OFS, 32'h0000_0005}
  };

endpackage

`default_nettype wire

//--- src/nbf_loader.sv
/*
  nbf boot loader
  walks the fixed boot image once after reset and issues every entry
  as a four-phase write on the loader channel, then flags completion
*/
`default_nettype none
`timescale 1ns/1ps

module nbf_loader
  import host_pkg::*;
(
  input  wire                clk_i,
  input  wire                rst_n_i,

  output logic               ld_req_o,
  output op_e                ld_op_o,
  output logic [ADDR_W-1:0]  ld_addr_o,
  output logic [DATA_W-1:0]  ld_wdata_o,
  input  wire                ld_ack_i,

  output logic               load_done_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT_DROP,
    S_DONE
  } ld_state_e;

  ld_state_e             state_q;
  logic [NBF_IDX_W-1:0]  idx_q;
  logic                  last_entry;

  assign last_entry = (idx_q == NBF_IDX_W'(NBF_LEN - 1));

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= S_IDLE;
      idx_q   <= '0;
    end
    else
    begin
      case (state_q)
        S_IDLE:
        begin
          state_q <= S_REQ;
        end
        // hold req until the router answers
        S_REQ:
        begin
          if (ld_ack_i)
          begin
            state_q <= S_WAIT_DROP;
          end
        end
        // ack must fall before the next entry starts
        S_WAIT_DROP:
        begin
          if (!ld_ack_i)
          begin
            if (last_entry)
            begin
              state_q <= S_DONE;
            end
            else
            begin
              idx_q   <= idx_q + 1'b1;
              state_q <= S_REQ;
            end
          end
        end
        // stays here until reset
        S_DONE:
        begin
          state_q <= S_DONE;
        end
        default:
        begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // command fields come straight from the image, stable while req is high
  assign ld_req_o    = (state_q == S_REQ);
  assign ld_op_o     = OP_WRITE;
  assign ld_addr_o   = nbf_image[idx_q].addr;
  assign ld_wdata_o  = nbf_image[idx_q].data;
  assign load_done_o = (state_q == S_DONE);

endmodule

`default_nettype wire

//--- src/backing_mem.sv
/*
  backing memory
  word-addressed RAM behind a four-phase req/ack target port,
  ack follows req by one cycle and the access happens on the
  edge that raises ack
*/
`default_nettype none
`timescale 1ns/1ps

module backing_mem
  import host_pkg::*;
(
  input  wire                clk_i,
  input  wire                rst_n_i,

  input  wire                mem_req_i,
  input  wire op_e           mem_op_i,
  input  wire [ADDR_W-1:0]   mem_addr_i,
  input  wire [DATA_W-1:0]   mem_wdata_i,
  output logic               mem_ack_o,
  output logic [DATA_W-1:0]  mem_rdata_o
);

  logic [DATA_W-1:0]     mem_q [MEM_WORDS];
  logic [MEM_IDX_W-1:0]  word_idx;
  logic                  ack_q;
  logic [DATA_W-1:0]     rdata_q;
  logic                  access;

  // byte address to word index
  assign word_idx = mem_addr_i[MEM_IDX_W+1:2];

  // first cycle of a request only
  assign access = mem_req_i && !ack_q;

  // ack tracks req one cycle late
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= mem_req_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (access && (mem_op_i == OP_WRITE))
    begin
      mem_q[word_idx] <= mem_wdata_i;
    end
  end

  // read data held until the next read
  always_ff @(posedge clk_i)
  begin
    if (access && (mem_op_i == OP_READ))
    begin
      rdata_q <= mem_q[word_idx];
    end
  end

  assign mem_ack_o   = ack_q;
  assign mem_rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- src/io_host.sv
/*
  host register block
  trace enable register and finish register on a four-phase
  req/ack target port; unmapped offsets read a fixed pattern
*/
`default_nettype none
`timescale 1ns/1ps

module io_host
  import host_pkg::*;
(
  input  wire                 clk_i,
  input  wire                 rst_n_i,

  input  wire                 host_req_i,
  input  wire op_e            host_op_i,
  input  wire [ADDR_W-1:0]    host_addr_i,
  input  wire [DATA_W-1:0]    host_wdata_i,
  output logic                host_ack_o,
  output logic [DATA_W-1:0]   host_rdata_o,

  output logic [TRACE_W-1:0]  trace_en_o,
  output logic                finish_o,
  output logic [CODE_W-1:0]   finish_code_o
);

  typedef enum logic [1:0] {
    REG_ENABLE,
    REG_FINISH,
    REG_NONE
  } host_reg_e;

  logic [ADDR_W-1:0]   ofs;
  host_reg_e           reg_sel;
  logic                ack_q;
  logic                access;
  logic [DATA_W-1:0]   rd_mux;
  logic [DATA_W-1:0]   rdata_q;
  logic [TRACE_W-1:0]  trace_en_q;
  logic                finish_q;
  logic [CODE_W-1:0]   finish_code_q;

  // strip the region bit to get the register offset
  assign ofs = host_addr_i & ~HOST_BASE;

  always_comb
  begin
    if (ofs == HOST_ENABLE_OFS)
    begin
      reg_sel = REG_ENABLE;
    end
    else if (ofs == HOST_FINISH_OFS)
    begin
      reg_sel = REG_FINISH;
    end
    else
    begin
      reg_sel = REG_NONE;
    end
  end

  always_comb
  begin
    case (reg_sel)
      REG_ENABLE: rd_mux = DATA_W'(trace_en_q);
      // code in 7:0, flag in bit 8
      REG_FINISH: rd_mux = DATA_W'({finish_q, finish_code_q});
      default:    rd_mux = HOST_BAD_RDATA;
    endcase
  end

  assign access = host_req_i && !ack_q;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      ack_q         <= 1'b0;
      trace_en_q    <= '0;
      finish_q      <= 1'b0;
      finish_code_q <= '0;
    end
    else
    begin
      ack_q <= host_req_i;
      if (access && (host_op_i == OP_WRITE))
      begin
        case (reg_sel)
          REG_ENABLE: trace_en_q <= host_wdata_i[TRACE_W-1:0];
          REG_FINISH:
          begin
            // flag is sticky until reset
            finish_q      <= 1'b1;
            finish_code_q <= host_wdata_i[CODE_W-1:0];
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (access && (host_op_i == OP_READ))
    begin
      rdata_q <= rd_mux;
    end
  end

  assign host_ack_o    = ack_q;
  assign host_rdata_o  = rdata_q;
  assign trace_en_o    = trace_en_q;
  assign finish_o      = finish_q;
  assign finish_code_o = finish_code_q;

endmodule

`default_nettype wire

//--- src/cmd_router.sv
/*
  command router
  grants the loader until loading is done and the processor after,
  one transaction at a time; latches the command, decodes the target
  from the host region bit and relays ack and read data back
*/
`default_nettype none
`timescale 1ns/1ps

module cmd_router
  import host_pkg::*;
(
  input  wire                clk_i,
  input  wire                rst_n_i,
  input  wire                load_done_i,

  input  wire                proc_req_i,
  input  wire op_e           proc_op_i,
  input  wire [ADDR_W-1:0]   proc_addr_i,
  input  wire [DATA_W-1:0]   proc_wdata_i,
  output logic               proc_ack_o,
  output logic [DATA_W-1:0]  proc_rdata_o,

  input  wire                ld_req_i,
  input  wire op_e           ld_op_i,
  input  wire [ADDR_W-1:0]   ld_addr_i,
  input  wire [DATA_W-1:0]   ld_wdata_i,
  output logic               ld_ack_o,

  output logic               mem_req_o,
  output op_e                mem_op_o,
  output logic [ADDR_W-1:0]  mem_addr_o,
  output logic [DATA_W-1:0]  mem_wdata_o,
  input  wire                mem_ack_i,
  input  wire [DATA_W-1:0]   mem_rdata_i,

  output logic               host_req_o,
  output op_e                host_op_o,
  output logic [ADDR_W-1:0]  host_addr_o,
  output logic [DATA_W-1:0]  host_wdata_o,
  input  wire                host_ack_i,
  input  wire [DATA_W-1:0]   host_rdata_i
);

  typedef enum logic [1:0] {
    R_IDLE,
    R_FWD,
    R_RESP
  } rt_state_e;

  rt_state_e          state_q;
  logic               req_q, ack_q, gnt_proc_q, host_sel_q;
  op_e                op_q;
  logic [ADDR_W-1:0]  addr_q;
  logic [DATA_W-1:0]  wdata_q, rdata_q;
  logic               new_req, rqst_req, tgt_ack;
  op_e                in_op;
  logic [ADDR_W-1:0]  in_addr;
  logic [DATA_W-1:0]  in_wdata, tgt_rdata;

  // processor is held off until the boot image is in
  assign new_req  = load_done_i ? proc_req_i   : ld_req_i;
  assign in_op    = load_done_i ? proc_op_i    : ld_op_i;
  assign in_addr  = load_done_i ? proc_addr_i  : ld_addr_i;
  assign in_wdata = load_done_i ? proc_wdata_i : ld_wdata_i;

  assign rqst_req  = gnt_proc_q ? proc_req_i : ld_req_i;
  assign tgt_ack   = host_sel_q ? host_ack_i : mem_ack_i;
  assign tgt_rdata = host_sel_q ? host_rdata_i : mem_rdata_i;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q    <= R_IDLE;
      req_q      <= 1'b0;
      ack_q      <= 1'b0;
      gnt_proc_q <= 1'b0;
      host_sel_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        R_IDLE:
        begin
          if (new_req)
          begin
            req_q      <= 1'b1;
            gnt_proc_q <= load_done_i;
            host_sel_q <= |(in_addr & HOST_BASE);
            state_q    <= R_FWD;
          end
        end
        // target done, drop its req and answer the requester
        R_FWD:
        begin
          if (tgt_ack)
          begin
            req_q   <= 1'b0;
            ack_q   <= 1'b1;
            state_q <= R_RESP;
          end
        end
        // both sides back to idle before the next grant
        R_RESP:
        begin
          if (!rqst_req && !tgt_ack)
          begin
            ack_q   <= 1'b0;
            state_q <= R_IDLE;
          end
        end
        default:
        begin
          state_q <= R_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if ((state_q == R_IDLE) && new_req)
    begin
      op_q    <= in_op;
      addr_q  <= in_addr;
      wdata_q <= in_wdata;
    end
    if ((state_q == R_FWD) && tgt_ack)
    begin
      rdata_q <= tgt_rdata;
    end
  end

  assign mem_req_o    = req_q && !host_sel_q;
  assign mem_op_o     = op_q;
  assign mem_addr_o   = addr_q;
  assign mem_wdata_o  = wdata_q;

  assign host_req_o   = req_q && host_sel_q;
  assign host_op_o    = op_q;
  assign host_addr_o  = addr_q;
  assign host_wdata_o = wdata_q;

  assign proc_ack_o   = ack_q && gnt_proc_q;
  assign proc_rdata_o = rdata_q;
  assign ld_ack_o     = ack_q && !gnt_proc_q;

endmodule

`default_nettype wire

//--- src/soc_host_top.sv
/*
  host-side top level
  boot loader, command router, backing memory and host registers
*/
`default_nettype none
`timescale 1ns/1ps

module soc_host_top
  import host_pkg::*;
(
  input  wire                 clk_i,
  input  wire                 rst_n_i,

  input  wire                 proc_req_i,
  input  wire op_e            proc_op_i,
  input  wire [ADDR_W-1:0]    proc_addr_i,
  input  wire [DATA_W-1:0]    proc_wdata_i,
  output logic                proc_ack_o,
  output logic [DATA_W-1:0]   proc_rdata_o,

  output logic                load_done_o,
  output logic [TRACE_W-1:0]  trace_en_o,
  output logic                finish_o,
  output logic [CODE_W-1:0]   finish_code_o
);

  // loader channel
  logic               ld_req, ld_ack;
  op_e                ld_op;
  logic [ADDR_W-1:0]  ld_addr;
  logic [DATA_W-1:0]  ld_wdata;

  // memory channel
  logic               mem_req, mem_ack;
  op_e                mem_op;
  logic [ADDR_W-1:0]  mem_addr;
  logic [DATA_W-1:0]  mem_wdata, mem_rdata;

  // host channel
  logic               host_req, host_ack;
  op_e                host_op;
  logic [ADDR_W-1:0]  host_addr;
  logic [DATA_W-1:0]  host_wdata, host_rdata;

  nbf_loader u_loader (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ld_req_o    (ld_req),
    .ld_op_o     (ld_op),
    .ld_addr_o   (ld_addr),
    .ld_wdata_o  (ld_wdata),
    .ld_ack_i    (ld_ack),
    .load_done_o (load_done_o)
  );

  cmd_router u_router (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .load_done_i  (load_done_o),
    .proc_req_i   (proc_req_i),
    .proc_op_i    (proc_op_i),
    .proc_addr_i  (proc_addr_i),
    .proc_wdata_i (proc_wdata_i),
    .proc_ack_o   (proc_ack_o),
    .proc_rdata_o (proc_rdata_o),
    .ld_req_i     (ld_req),
    .ld_op_i      (ld_op),
    .ld_addr_i    (ld_addr),
    .ld_wdata_i   (ld_wdata),
    .ld_ack_o     (ld_ack),
    .mem_req_o    (mem_req),
    .mem_op_o     (mem_op),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_ack_i    (mem_ack),
    .mem_rdata_i  (mem_rdata),
    .host_req_o   (host_req),
    .host_op_o    (host_op),
    .host_addr_o  (host_addr),
    .host_wdata_o (host_wdata),
    .host_ack_i   (host_ack),
    .host_rdata_i (host_rdata)
  );

  backing_mem u_mem (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_req_i   (mem_req),
    .mem_op_i    (mem_op),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_ack_o   (mem_ack),
    .mem_rdata_o (mem_rdata)
  );

  io_host u_host (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .host_req_i    (host_req),
    .host_op_i     (host_op),
    .host_addr_i   (host_addr),
    .host_wdata_i  (host_wdata),
    .host_ack_o    (host_ack),
    .host_rdata_o  (host_rdata),
    .trace_en_o    (trace_en_o),
    .finish_o      (finish_o),
    .finish_code_o (finish_code_o)
  );

endmodule

`default_nettype wire

//--- dv/tb_soc_host_props.sv
/*
  handshake and status properties
  bound into the command router and the host register block,
  checks the four-phase rules, the sticky finish flag and the
  processor back-pressure before the boot image is loaded
*/
`default_nettype none
`timescale 1ns/1ps

module tb_soc_host_props (
  input wire clk_i,
  input wire rst_n_i,
  input wire req_a_i,
  input wire ack_a_i,
  input wire req_b_i,
  input wire ack_b_i,
  input wire req_c_i,
  input wire ack_c_i,
  input wire finish_i,
  input wire load_done_i,
  input wire proc_ack_i
);

  // req held until its ack
  a_req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_a_i && !ack_a_i) |=> req_a_i)
    else $error("channel a dropped req before ack");
  a_req_hold_b: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_b_i && !ack_b_i) |=> req_b_i)
    else $error("channel b dropped req before ack");
  a_req_hold_c: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_c_i && !ack_c_i) |=> req_c_i)
    else $error("channel c dropped req before ack");

  // ack stays up while req is high
  a_ack_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_a_i && ack_a_i) |=> ack_a_i)
    else $error("channel a dropped ack while req high");
  a_ack_hold_b: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_b_i && ack_b_i) |=> ack_b_i)
    else $error("channel b dropped ack while req high");
  a_ack_hold_c: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_c_i && ack_c_i) |=> ack_c_i)
    else $error("channel c dropped ack while req high");

  a_finish_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    finish_i |=> finish_i)
    else $error("finish flag fell outside reset");

  a_proc_backpressure: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !load_done_i |-> !proc_ack_i)
    else $error("processor acked before load done");

endmodule

// router side: processor, loader and memory channels
bind cmd_router tb_soc_host_props u_router_props (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .req_a_i     (proc_req_i),
  .ack_a_i     (proc_ack_o),
  .req_b_i     (ld_req_i),
  .ack_b_i     (ld_ack_o),
  .req_c_i     (mem_req_o),
  .ack_c_i     (mem_ack_i),
  .finish_i    (1'b0),
  .load_done_i (load_done_i),
  .proc_ack_i  (proc_ack_o)
);

// host side: host channel and finish flag
bind io_host tb_soc_host_props u_host_props (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .req_a_i     (host_req_i),
  .ack_a_i     (host_ack_o),
  .req_b_i     (1'b0),
  .ack_b_i     (1'b0),
  .req_c_i     (1'b0),
  .ack_c_i     (1'b0),
  .finish_i    (finish_o),
  .load_done_i (1'b1),
  .proc_ack_i  (1'b0)
);

`default_nettype wire

//--- dv/tb_soc_host.sv
/*
  host-side system testbench
  stands in for the processor on the proc channel and walks a table
  of reads and writes through the DUT while the boot image loads
*/
`default_nettype none
`timescale 1ns/1ps

module tb_soc_host;
  import host_pkg::*;

  localparam int NUM_TESTS = 15;
  localparam int RST_CYCLES = 8;
  localparam int WDOG_CYCLES = (NUM_TESTS + NBF_LEN) * 20 + RST_CYCLES;

  logic                clk;
  logic                rst_n;
  logic                proc_req;
  op_e                 proc_op;
  logic [ADDR_W-1:0]   proc_addr;
  logic [DATA_W-1:0]   proc_wdata;
  wire                 proc_ack;
  wire  [DATA_W-1:0]   proc_rdata;
  wire                 load_done;
  wire  [TRACE_W-1:0]  trace_en;
  wire                 finish;
  wire  [CODE_W-1:0]   finish_code;

  // stimulus and expected values per test row
  string               name_t [NUM_TESTS];
  op_e                 op_t [NUM_TESTS];
  logic [ADDR_W-1:0]   addr_t [NUM_TESTS];
  logic [DATA_W-1:0]   wdata_t [NUM_TESTS];
  logic [DATA_W-1:0]   exp_t [NUM_TESTS];
  logic                chk_t [NUM_TESTS];
  logic [TRACE_W-1:0]  exp_trace_t [NUM_TESTS];
  logic                exp_finish_t [NUM_TESTS];
  logic [CODE_W-1:0]   exp_code_t [NUM_TESTS];

  // running model of the host registers
  logic [TRACE_W-1:0]  mdl_trace;
  logic                mdl_finish;
  logic [CODE_W-1:0]   mdl_code;

  int                  n_rows;
  int                  errors;
  int                  checks;
  logic [DATA_W-1:0]   got;
  logic [DATA_W-1:0]   rnd;

  soc_host_top UUT (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .proc_req_i    (proc_req),
    .proc_op_i     (proc_op),
    .proc_addr_i   (proc_addr),
    .proc_wdata_i  (proc_wdata),
    .proc_ack_o    (proc_ack),
    .proc_rdata_o  (proc_rdata),
    .load_done_o   (load_done),
    .trace_en_o    (trace_en),
    .finish_o      (finish),
    .finish_code_o (finish_code)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial
  begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not complete within %0d cycles", WDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

  task automatic add_row(input string name, input op_e op, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] exp,
                         input logic chk);
    name_t[n_rows]       = name;
    op_t[n_rows]         = op;
    addr_t[n_rows]       = addr;
    wdata_t[n_rows]      = wdata;
    exp_t[n_rows]        = exp;
    chk_t[n_rows]        = chk;
    exp_trace_t[n_rows]  = mdl_trace;
    exp_finish_t[n_rows] = mdl_finish;
    exp_code_t[n_rows]   = mdl_code;
    n_rows++;
  endtask

  task automatic build_table();
    logic [DATA_W-1:0] w;
    n_rows     = 0;
    // last boot entry enables traces 0 and 2
    mdl_trace  = 8'h05;
    mdl_finish = 1'b0;
    mdl_code   = '0;
    for (int i = 0; i < 7; i++)
    begin
      add_row($sformatf("boot_word_%0d", i), OP_READ, ADDR_W'(i * 4), '0,
              32'h1000_0000 + i * 32'h0101, 1'b1);
    end
    w = rnd;
    add_row("mem_write_w100", OP_WRITE, 16'h0190, w, '0, 1'b0);
    add_row("mem_read_w100", OP_READ, 16'h0190, '0, w, 1'b1);
    add_row("host_enable_boot", OP_READ, 16'h8000, '0, 32'h0000_0005, 1'b1);
    w = $urandom;
    mdl_trace = w[7:0];
    add_row("host_enable_write", OP_WRITE, 16'h8000, w, '0, 1'b0);
    add_row("host_enable_read", OP_READ, 16'h8000, '0, {24'h0, w[7:0]}, 1'b1);
    add_row("host_unmapped", OP_READ, 16'h8008, '0, 32'hDEAD_BEEF, 1'b1);
    w = $urandom;
    mdl_finish = 1'b1;
    mdl_code   = w[7:0];
    add_row("host_finish_write", OP_WRITE, 16'h8004, w, '0, 1'b0);
    add_row("host_finish_read", OP_READ, 16'h8004, '0, {23'h0, 1'b1, w[7:0]}, 1'b1);
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  // one full four-phase transaction on the proc port
  // outputs are sampled on the falling edge
  task automatic run_transfer(input int t, output logic [DATA_W-1:0] rdata);
    @(posedge clk);
    proc_req   <= 1'b1;
    proc_op    <= op_t[t];
    proc_addr  <= addr_t[t];
    proc_wdata <= wdata_t[t];
    do @(negedge clk); while (!proc_ack);
    rdata = proc_rdata;
    @(posedge clk);
    proc_req <= 1'b0;
    do @(negedge clk); while (proc_ack);
  endtask

  initial
  begin
    errors     = 0;
    checks     = 0;
    rst_n      = 1'b0;
    proc_req   = 1'b0;
    proc_op    = OP_READ;
    proc_addr  = '0;
    proc_wdata = '0;
    rnd = $urandom(32'h20218fa4);
    build_table();

    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("reset load_done", 32'(0), 32'(load_done));
    check_value("reset finish", 32'(0), 32'(finish));
    check_value("reset trace_en", 32'(0), 32'(trace_en));
    check_value("reset finish_code", 32'(0), 32'(finish_code));
    check_value("reset proc_ack", 32'(0), 32'(proc_ack));

    // first request goes out while the loader still owns the router
    for (int t = 0; t < n_rows; t++)
    begin
      run_transfer(t, got);
      if (chk_t[t])
      begin
        check_value(name_t[t], exp_t[t], got);
      end
      check_value({name_t[t], " load_done"}, 32'(1), 32'(load_done));
      check_value({name_t[t], " trace_en"}, 32'(exp_trace_t[t]), 32'(trace_en));
      check_value({name_t[t], " finish"}, 32'(exp_finish_t[t]), 32'(finish));
      check_value({name_t[t], " finish_code"}, 32'(exp_code_t[t]), 32'(finish_code));
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
    begin
      $display("all tests passed");
    end
    else
    begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
src/host_pkg.sv
src/nbf_loader.sv
src/backing_mem.sv
src/io_host.sv
src/cmd_router.sv
src/soc_host_top.sv
dv/tb_soc_host_props.sv
dv/tb_soc_host.sv
